//--- Bender.yml
package:
  name: wh_mem_subsys

sources:
  - files:
      - logic/wh_pkg.sv
      - logic/wh_rr_arbiter.sv
      - logic/wh_concentrator.sv
      - logic/wh_test_mem.sv
      - logic/wh_mem_subsys.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_wh_mem_subsys.sv

//--- logic/wh_concentrator.sv
`timescale 1ns/100ps

module wh_concentrator import wh_pkg::*; #(
  parameter int NUM_IN_P = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  wh_link_s [NUM_IN_P-1:0] links_i,
  output wh_link_s [NUM_IN_P-1:0] links_o,
  input  wh_link_s                conc_link_i,
  output wh_link_s                conc_link_o
);

  logic [NUM_IN_P-1:0]  req;
  logic [NUM_IN_P-1:0]  grant;
  logic                 hold;
  logic                 lock_r;
  logic [LEN_WIDTH-1:0] req_cnt_r;
  logic                 req_xfer;
  wh_header_s           req_hdr;

  logic                 route_r;
  logic [LEN_WIDTH-1:0] resp_cnt_r;
  logic [CID_WIDTH-1:0] resp_idx_r;
  logic [CID_WIDTH-1:0] resp_sel;
  logic                 resp_ready;
  logic                 resp_xfer;
  wh_header_s           resp_hdr;

  // request path

  always_comb begin
    for (int k = 0; k < NUM_IN_P; k++) begin
      req[k] = links_i[k].v;
    end
  end

  wh_rr_arbiter #(
    .NUM_IN_P(NUM_IN_P)
  ) u_wh_rr_arbiter (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (req),
    .hold_i (hold),
    .grant_o(grant)
  );

  assign req_hdr  = wh_header_s'(conc_link_o.data);
  assign req_xfer = conc_link_o.v && conc_link_i.ready_and_rev;

  // keep the grant through a stalled header and until the last body flit
  always_comb begin
    if (lock_r) begin
      hold = !(req_xfer && (req_cnt_r == LEN_WIDTH'(1)));
    end else begin
      hold = conc_link_o.v && (!req_xfer || (req_hdr.len != '0));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_r    <= 1'b0;
      req_cnt_r <= '0;
    end else if (!lock_r) begin
      if (req_xfer && (req_hdr.len != '0)) begin
        lock_r    <= 1'b1;
        req_cnt_r <= req_hdr.len;
      end
    end else if (req_xfer) begin
      req_cnt_r <= req_cnt_r - 1'b1;
      if (req_cnt_r == LEN_WIDTH'(1)) begin
        lock_r <= 1'b0;
      end
    end
  end

  // response path

  assign resp_hdr  = wh_header_s'(conc_link_i.data);
  assign resp_sel  = route_r ? resp_idx_r : resp_hdr.cid;
  assign resp_xfer = conc_link_i.v && resp_ready;

  always_comb begin
    resp_ready = 1'b0;
    for (int k = 0; k < NUM_IN_P; k++) begin
      if (resp_sel == CID_WIDTH'(k)) begin
        resp_ready = links_i[k].ready_and_rev;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      route_r    <= 1'b0;
      resp_cnt_r <= '0;
      resp_idx_r <= '0;
    end else if (!route_r) begin
      if (resp_xfer && (resp_hdr.len != '0)) begin
        route_r    <= 1'b1;
        resp_cnt_r <= resp_hdr.len;
        resp_idx_r <= resp_hdr.cid;
      end
    end else if (resp_xfer) begin
      resp_cnt_r <= resp_cnt_r - 1'b1;
      if (resp_cnt_r == LEN_WIDTH'(1)) begin
        route_r <= 1'b0;
      end
    end
  end

  // granted input onto the concentrated link
  always_comb begin
    conc_link_o.v             = 1'b0;
    conc_link_o.data          = '0;
    conc_link_o.ready_and_rev = resp_ready;
    for (int k = 0; k < NUM_IN_P; k++) begin
      if (grant[k]) begin
        conc_link_o.v    = links_i[k].v;
        conc_link_o.data = links_i[k].data;
      end
    end
  end

  // responses steered by cid, ready only to the granted input
  always_comb begin
    for (int k = 0; k < NUM_IN_P; k++) begin
      links_o[k].v             = conc_link_i.v && (resp_sel == CID_WIDTH'(k));
      links_o[k].data          = conc_link_i.data;
      links_o[k].ready_and_rev = grant[k] && conc_link_i.ready_and_rev;
    end
  end

endmodule

//--- logic/wh_mem_subsys.sv
`timescale 1ns/100ps

module wh_mem_subsys import wh_pkg::*; #(
  parameter int NUM_IN_P    = 4,
  parameter int MEM_WORDS_P = 256
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  wh_link_s [NUM_IN_P-1:0] links_i,
  output wh_link_s [NUM_IN_P-1:0] links_o
);

  // concentrated link, one struct per direction
  wh_link_s conc_to_mem;
  wh_link_s mem_to_conc;

  wh_concentrator #(
    .NUM_IN_P(NUM_IN_P)
  ) u_wh_concentrator (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .links_i    (links_i),
    .links_o    (links_o),
    .conc_link_i(mem_to_conc),
    .conc_link_o(conc_to_mem)
  );

  wh_test_mem #(
    .MEM_WORDS_P(MEM_WORDS_P)
  ) u_wh_test_mem (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .link_i (conc_to_mem),
    .link_o (mem_to_conc)
  );

endmodule

//--- logic/wh_pkg.sv
package wh_pkg;

  localparam int FLIT_WIDTH = 32;
  localparam int CID_WIDTH  = 4;
  localparam int LEN_WIDTH  = 4;
  localparam int ADDR_WIDTH = 20;

  // request and response opcodes
  typedef enum logic [3:0] {
    WH_OP_READ      = 4'd0,
    WH_OP_WRITE     = 4'd1,
    WH_OP_READ_RESP = 4'd2,
    WH_OP_WRITE_ACK = 4'd3
  } wh_op_e;

  // header flit, len counts the body flits that follow
  typedef struct packed {
    wh_op_e                op;
    logic [CID_WIDTH-1:0]  cid;
    logic [LEN_WIDTH-1:0]  len;
    logic [ADDR_WIDTH-1:0] addr;
  } wh_header_s;

  // ready_and link, v and data go forward, ready_and_rev goes back
  typedef struct packed {
    logic                  v;
    logic                  ready_and_rev;
    logic [FLIT_WIDTH-1:0] data;
  } wh_link_s;

endpackage

//--- logic/wh_rr_arbiter.sv
`timescale 1ns/100ps

module wh_rr_arbiter #(
  parameter int NUM_IN_P = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [NUM_IN_P-1:0] req_i,
  input  logic                hold_i,
  output logic [NUM_IN_P-1:0] grant_o
);

  localparam int PTR_W = (NUM_IN_P > 1) ? $clog2(NUM_IN_P) : 1;

  logic [PTR_W-1:0] ptr_r;
  logic [PTR_W-1:0] held_idx_r;
  logic             held_r;
  logic [PTR_W-1:0] pick_idx;
  logic [PTR_W-1:0] cur_idx;
  logic             found;
  logic             granted;
  int               scan;

  // first requester at or after the pointer
  always_comb begin
    found    = 1'b0;
    pick_idx = ptr_r;
    scan     = 0;
    for (int i = 0; i < NUM_IN_P; i++) begin
      scan = int'(ptr_r) + i;
      if (scan >= NUM_IN_P) begin
        scan = scan - NUM_IN_P;
      end
      if (!found && req_i[scan]) begin
        found    = 1'b1;
        pick_idx = PTR_W'(scan);
      end
    end
  end

  assign cur_idx = held_r ? held_idx_r : pick_idx;
  assign granted = held_r || found;

  always_comb begin
    grant_o = '0;
    if (granted) begin
      grant_o[cur_idx] = 1'b1;
    end
  end

  // hold_i keeps the current winner for the next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_r      <= '0;
      held_idx_r <= '0;
      held_r     <= 1'b0;
    end else begin
      held_r <= hold_i;
      if (hold_i) begin
        held_idx_r <= cur_idx;
      end
      // grant released, winner drops to lowest priority
      if (!hold_i && granted) begin
        ptr_r <= (cur_idx == PTR_W'(NUM_IN_P - 1)) ? '0 : cur_idx + 1'b1;
      end
    end
  end

endmodule

//--- logic/wh_test_mem.sv
`timescale 1ns/100ps

module wh_test_mem import wh_pkg::*; #(
  parameter int MEM_WORDS_P = 256
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  wh_link_s link_i,
  output wh_link_s link_o
);

  localparam int MEM_AW = (MEM_WORDS_P > 1) ? $clog2(MEM_WORDS_P) : 1;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BODY,
    RESP_HDR,
    RESP_DATA
  } state_e;

  state_e               state_r;
  state_e               state_nxt;
  logic [LEN_WIDTH-1:0] cnt_r;
  wh_header_s           req_hdr;
  wh_header_s           hdr_r;
  wh_header_s           resp_hdr;
  logic [MEM_AW-1:0]    hdr_idx;
  logic [MEM_AW-1:0]    wr_idx_r;
  logic [FLIT_WIDTH-1:0] rd_data_r;
  logic                 in_ready;
  logic                 in_xfer;
  logic                 out_xfer;
  logic                 is_write;
  logic                 wr_en;

  logic [FLIT_WIDTH-1:0] mem [MEM_WORDS_P];

  assign req_hdr  = wh_header_s'(link_i.data);
  assign hdr_idx  = MEM_AW'(req_hdr.addr % MEM_WORDS_P);
  assign is_write = (req_hdr.op == WH_OP_WRITE);

  // one packet in flight, input stalls while responding
  assign in_ready = (state_r == IDLE) || (state_r == WRITE_BODY);
  assign in_xfer  = link_i.v && in_ready;
  assign out_xfer = link_o.v && link_i.ready_and_rev;
  assign wr_en    = in_xfer && (state_r == WRITE_BODY);

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      IDLE: begin
        if (in_xfer) begin
          state_nxt = (is_write && (req_hdr.len != '0)) ? WRITE_BODY : RESP_HDR;
        end
      end
      WRITE_BODY: begin
        if (in_xfer && (cnt_r == LEN_WIDTH'(1))) begin
          state_nxt = RESP_HDR;
        end
      end
      RESP_HDR: begin
        if (out_xfer) begin
          state_nxt = (hdr_r.op == WH_OP_WRITE) ? IDLE : RESP_DATA;
        end
      end
      RESP_DATA: begin
        if (out_xfer) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= IDLE;
      cnt_r   <= '0;
    end else begin
      state_r <= state_nxt;
      if (state_r == IDLE && in_xfer) begin
        cnt_r <= req_hdr.len;
      end else if (wr_en) begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

  // request header and write pointer
  always_ff @(posedge clk_i) begin
    if (state_r == IDLE && in_xfer) begin
      hdr_r    <= req_hdr;
      wr_idx_r <= hdr_idx;
    end else if (wr_en) begin
      wr_idx_r <= (wr_idx_r == MEM_AW'(MEM_WORDS_P - 1)) ? '0 : wr_idx_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_idx_r] <= link_i.data;
    end
  end

  // read word fetched with the header
  always_ff @(posedge clk_i) begin
    if (state_r == IDLE && in_xfer && !is_write) begin
      rd_data_r <= mem[hdr_idx];
    end
  end

  always_comb begin
    resp_hdr.cid  = hdr_r.cid;
    resp_hdr.addr = hdr_r.addr;
    if (hdr_r.op == WH_OP_WRITE) begin
      resp_hdr.op  = WH_OP_WRITE_ACK;
      resp_hdr.len = '0;
    end else begin
      resp_hdr.op  = WH_OP_READ_RESP;
      resp_hdr.len = LEN_WIDTH'(1);
    end
  end

  always_comb begin
    link_o.ready_and_rev = in_ready;
    link_o.v             = (state_r == RESP_HDR) || (state_r == RESP_DATA);
    link_o.data          = (state_r == RESP_DATA) ? rd_data_r : FLIT_WIDTH'(resp_hdr);
  end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // reset low for the first 3 cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- verification/tb_wh_mem_subsys.sv
`timescale 1ns/100ps

module tb_wh_mem_subsys import wh_pkg::*; ();

  localparam int NUM_IN         = 4;
  localparam int MEM_WORDS      = 256;
  localparam int NUM_ROWS       = 20;
  localparam int TB_CYCLE_LIMIT = NUM_ROWS * 40;

  // one table row per request packet
  typedef struct packed {
    logic [1:0]                 port;
    wh_op_e                     op;
    logic [ADDR_WIDTH-1:0]      addr;
    logic [LEN_WIDTH-1:0]       len;
    logic [3:0][FLIT_WIDTH-1:0] data;
    logic [3:0]                 grp;
  } stim_row_s;

  logic                  clk;
  logic                  rst_n;
  wh_link_s [NUM_IN-1:0] links_i;
  wh_link_s [NUM_IN-1:0] links_o;
  stim_row_s             stim_tab [NUM_ROWS];
  logic [FLIT_WIDTH-1:0] ref_mem [MEM_WORDS];
  logic [31:0]           lcg_state;
  int                    row_of [NUM_IN];
  int                    flit_idx [NUM_IN];
  int                    rsp_cnt [NUM_IN];
  bit                    req_xfer [NUM_IN];
  int                    pending;
  int                    n_rows;
  int                    cycle_cnt;

  tb_clk_gen u_tb_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  wh_mem_subsys #(
    .NUM_IN_P   (NUM_IN),
    .MEM_WORDS_P(MEM_WORDS)
  ) u_wh_mem_subsys (
    .clk_i  (clk),
    .rst_n_i(rst_n),
    .links_i(links_i),
    .links_o(links_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("Failure at %0t: %s", $time, what);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic add_row(input int port, input wh_op_e op, input int addr, input int len,
                         input logic [31:0] d0, d1, d2, d3, input int grp);
    stim_tab[n_rows] = '{2'(port), op, ADDR_WIDTH'(addr), LEN_WIDTH'(len),
                         {d3, d2, d1, d0}, 4'(grp)};
    n_rows++;
  endtask

  // port, op, addr, len, data0 to data3, group
  task automatic fill_table();
    add_row(0, WH_OP_WRITE, 'h010, 3, 'h1111_0001, 'h1111_0002, 'h1111_0003, 0, 0);
    add_row(0, WH_OP_READ,  'h010, 0, 0, 0, 0, 0, 1);
    add_row(1, WH_OP_READ,  'h011, 0, 0, 0, 0, 0, 1);
    add_row(2, WH_OP_READ,  'h012, 0, 0, 0, 0, 0, 1);
    add_row(1, WH_OP_WRITE, 'h020, 2, 'h2222_0001, 'h2222_0002, 0, 0, 2);
    add_row(2, WH_OP_WRITE, 'h030, 1, 'h3333_0001, 0, 0, 0, 2);
    add_row(3, WH_OP_WRITE, 'h040, 4, 'h4444_0001, 'h4444_0002, 'h4444_0003, 'h4444_0004, 2);
    add_row(3, WH_OP_READ,  'h021, 0, 0, 0, 0, 0, 3);
    add_row(2, WH_OP_READ,  'h043, 0, 0, 0, 0, 0, 3);
    add_row(0, WH_OP_READ,  'h030, 0, 0, 0, 0, 0, 3);
    add_row(1, WH_OP_READ,  'h020, 0, 0, 0, 0, 0, 3);
    // same range from two inputs so the last ack wins per address
    add_row(1, WH_OP_WRITE, 'h060, 4, 'h6666_0001, 'h6666_0002, 'h6666_0003, 'h6666_0004, 4);
    add_row(2, WH_OP_WRITE, 'h060, 4, 'h7777_0001, 'h7777_0002, 'h7777_0003, 'h7777_0004, 4);
    add_row(0, WH_OP_READ,  'h060, 0, 0, 0, 0, 0, 5);
    add_row(1, WH_OP_READ,  'h061, 0, 0, 0, 0, 0, 5);
    add_row(2, WH_OP_READ,  'h062, 0, 0, 0, 0, 0, 5);
    add_row(3, WH_OP_READ,  'h063, 0, 0, 0, 0, 0, 5);
    add_row(3, WH_OP_WRITE, 'h105, 1, 'hCAFE_0105, 0, 0, 0, 6);
    add_row(0, WH_OP_READ,  'h005, 0, 0, 0, 0, 0, 7);
    add_row(1, WH_OP_WRITE, 'h070, 0, 0, 0, 0, 0, 7);
  endtask

  // header for idx 0 and body words after it
  function automatic logic [FLIT_WIDTH-1:0] req_flit(input int r, input int idx);
    wh_header_s hdr;
    hdr = '{stim_tab[r].op, CID_WIDTH'(stim_tab[r].port), stim_tab[r].len, stim_tab[r].addr};
    if (idx == 0) begin
      return FLIT_WIDTH'(hdr);
    end else begin
      return stim_tab[r].data[idx-1];
    end
  endfunction

  task automatic check_response(input int k);
    wh_header_s exp;
    int         r;
    int         a;
    r = row_of[k];
    if (rsp_cnt[k] == 0) begin
      exp.op   = (stim_tab[r].op == WH_OP_WRITE) ? WH_OP_WRITE_ACK : WH_OP_READ_RESP;
      exp.cid  = CID_WIDTH'(k);
      exp.len  = (stim_tab[r].op == WH_OP_WRITE) ? LEN_WIDTH'(0) : LEN_WIDTH'(1);
      exp.addr = stim_tab[r].addr;
      check_value($sformatf("links_o[%0d].data header", k), exp, links_o[k].data);
      if (stim_tab[r].op == WH_OP_WRITE) begin
        for (int i = 0; i < int'(stim_tab[r].len); i++) begin
          a = (int'(stim_tab[r].addr) + i) % MEM_WORDS;
          ref_mem[a] = stim_tab[r].data[i];
        end
      end
    end else begin
      a = int'(stim_tab[r].addr) % MEM_WORDS;
      check_value($sformatf("links_o[%0d].data read word", k), ref_mem[a], links_o[k].data);
    end
    rsp_cnt[k]++;
    if (rsp_cnt[k] == ((stim_tab[r].op == WH_OP_WRITE) ? 1 : 2)) begin
      row_of[k] = -1;
      pending--;
    end
  endtask

  // sampled mid-cycle where values equal those at the next rising edge
  task automatic observe_cycle();
    int n_ready;
    n_ready = 0;
    for (int k = 0; k < NUM_IN; k++) begin
      req_xfer[k] = links_i[k].v && links_o[k].ready_and_rev;
      if (links_o[k].ready_and_rev) begin
        n_ready++;
      end
      if (links_o[k].v) begin
        check_true(row_of[k] >= 0,
                   $sformatf("response on links_o[%0d] with no request outstanding", k));
        check_true(flit_idx[k] > int'(stim_tab[row_of[k]].len),
                   $sformatf("response on links_o[%0d] before its request ended", k));
        if (links_i[k].ready_and_rev) begin
          check_response(k);
        end
      end
    end
    check_true(n_ready <= 1, "request ready is high on more than one input at once");
  endtask

  task automatic drive_cycle();
    int r;
    for (int k = 0; k < NUM_IN; k++) begin
      r = row_of[k];
      if (req_xfer[k]) begin
        flit_idx[k]++;
      end
      req_xfer[k] = 1'b0;
      lcg_state = lcg_next(lcg_state);
      links_i[k].ready_and_rev = lcg_state[30] | lcg_state[28];
      if (r >= 0 && flit_idx[k] <= int'(stim_tab[r].len)) begin
        links_i[k].v    = 1'b1;
        links_i[k].data = req_flit(r, flit_idx[k]);
      end else begin
        links_i[k].v    = 1'b0;
        links_i[k].data = '0;
      end
    end
  endtask

  initial begin
    int row;
    int grp;
    links_i   = '0;
    lcg_state = 32'h95;
    pending   = 0;
    n_rows    = 0;
    for (int k = 0; k < NUM_IN; k++) begin
      row_of[k]   = -1;
      flit_idx[k] = 0;
      rsp_cnt[k]  = 0;
      req_xfer[k] = 1'b0;
    end
    fill_table();
    wait (rst_n === 1'b1);
    repeat (2) begin
      @(negedge clk);
      for (int k = 0; k < NUM_IN; k++) begin
        check_value($sformatf("links_o[%0d].v", k), 32'd0, 32'(links_o[k].v));
      end
    end
    @(posedge clk);
    #1;
    row = 0;
    while (row < NUM_ROWS) begin
      // launch a whole group and wait for all of its responses
      grp = stim_tab[row].grp;
      while (row < NUM_ROWS && int'(stim_tab[row].grp) == grp) begin
        row_of[stim_tab[row].port]   = row;
        flit_idx[stim_tab[row].port] = 0;
        rsp_cnt[stim_tab[row].port]  = 0;
        pending++;
        row++;
      end
      drive_cycle();
      while (pending > 0) begin
        @(negedge clk);
        observe_cycle();
        @(posedge clk);
        #1;
        drive_cycle();
      end
    end
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TB_CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run was still busy after %0d clock cycles", TB_CYCLE_LIMIT);
    $display("Test failed");
    $fatal(1);
  end

endmodule

//--- wh_mem_subsys.f
logic/wh_pkg.sv
logic/wh_rr_arbiter.sv
logic/wh_concentrator.sv
logic/wh_test_mem.sv
logic/wh_mem_subsys.sv
verification/tb_clk_gen.sv
verification/tb_wh_mem_subsys.sv
